//--- hw/port_router_pkg.sv
/* Echo router shared definitions */

`default_nettype none

package port_router_pkg;

    //////////////////////////////////////////////////////////////////////
    // Port layout and sizing

    // 8-bit ports own the low port numbers, 32-bit ports follow
    localparam int NUM_8B_PORTS  = 2;
    localparam int NUM_32B_PORTS = 2;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS;

    localparam int BEAT_FIFO_DEPTH  = 16;
    localparam int FIFO_PTR_WIDTH   = $clog2(BEAT_FIFO_DEPTH);
    localparam int FIFO_LEVEL_WIDTH = $clog2(BEAT_FIFO_DEPTH + 1);

    localparam int PKT_CNT_WIDTH = 16;

    //////////////////////////////////////////////////////////////////////
    // Beat and status types

    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
    } beat_8b_t;

    typedef struct packed {
        logic [31:0] tdata;
        logic [3:0]  tkeep;
        logic        tlast;
    } beat_32b_t;

    typedef struct packed {
        logic [PKT_CNT_WIDTH-1:0] ing_pkt_cnt;
        logic [PKT_CNT_WIDTH-1:0] egr_pkt_cnt;
        logic                     overflow;
    } port_status_t;

endpackage

`default_nettype wire

//--- hw/packet_counter.sv
/* Saturating packet counter */

`default_nettype none
`timescale 1ns/1ps

module packet_counter
    import port_router_pkg::*;
(
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst_n,
    input  logic                     last_seen,
    input  logic                     clear,
    output logic [PKT_CNT_WIDTH-1:0] count
);

    logic at_max;

    assign at_max = &count;

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            // A last beat on the clear edge is lost
            count <= '0;
        end else if (last_seen && !at_max) begin
            count <= count + PKT_CNT_WIDTH'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_monotonic: assert property (
        @(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !clear |=> count >= $past(count)
    );

endmodule

`default_nettype wire

//--- hw/beat_fifo.sv
/* Show-ahead beat buffer */

`default_nettype none
`timescale 1ns/1ps

module beat_fifo
    import port_router_pkg::*;
#(
    parameter type BEAT_T = beat_8b_t
) (
    input  logic  phys_port_clk_ifc,
    input  logic  rst_n,
    input  logic  wr_valid,
    input  BEAT_T wr_beat,
    input  logic  rd_ready,
    input  logic  clear,
    output logic  rd_valid,
    output BEAT_T rd_beat,
    output logic  overflow
);

    BEAT_T                       mem [BEAT_FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_LEVEL_WIDTH-1:0] count;
    logic                        full;
    logic                        do_wr;
    logic                        do_rd;

    assign full     = (count == FIFO_LEVEL_WIDTH'(BEAT_FIFO_DEPTH));
    assign do_wr    = wr_valid && !full;
    assign do_rd    = rd_valid && rd_ready;

    // Head entry is visible as soon as it is written
    assign rd_valid = (count != '0);
    assign rd_beat  = mem[rd_ptr];

    always_ff @(posedge phys_port_clk_ifc) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(BEAT_FIFO_DEPTH - 1)) ?
                          '0 : wr_ptr + FIFO_PTR_WIDTH'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(BEAT_FIFO_DEPTH - 1)) ?
                          '0 : rd_ptr + FIFO_PTR_WIDTH'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + FIFO_LEVEL_WIDTH'(1);
                2'b01:   count <= count - FIFO_LEVEL_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    // Sticky drop flag, clear wins over a same-cycle drop
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (clear) begin
            overflow <= 1'b0;
        end else if (wr_valid && full) begin
            overflow <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_count_bound: assert property (
        @(posedge phys_port_clk_ifc) disable iff (!rst_n)
        count <= FIFO_LEVEL_WIDTH'(BEAT_FIFO_DEPTH)
    );

    // Stalled head must hold until taken
    a_head_stable: assert property (
        @(posedge phys_port_clk_ifc) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_beat)
    );

endmodule

`default_nettype wire

//--- hw/echo_port.sv
/* Single physical echo port */

`default_nettype none
`timescale 1ns/1ps

module echo_port
    import port_router_pkg::*;
#(
    parameter type BEAT_T = beat_8b_t
) (
    input  logic         phys_port_clk_ifc,
    input  logic         rst_n,
    input  logic         ing_valid,
    input  BEAT_T        ing_beat,
    input  logic         enable,
    input  logic         cnt_clear,
    input  logic         egr_ready,
    output logic         egr_valid,
    output BEAT_T        egr_beat,
    output port_status_t status
);

    logic                        pkt_open;
    logic                        pkt_accept;
    logic                        beat_accept;
    logic                        wr_en;
    logic                        wr_ok;
    logic                        rd_ok;
    logic                        buf_full;
    logic [FIFO_LEVEL_WIDTH-1:0] level;
    logic                        ing_last_seen;
    logic                        egr_last_seen;
    logic                        overflow;
    logic [PKT_CNT_WIDTH-1:0]    ing_cnt;
    logic [PKT_CNT_WIDTH-1:0]    egr_cnt;

    //////////////////////////////////////////////////////////////////////
    // Enable sampled only on the first beat of a packet

    assign beat_accept = pkt_open ? pkt_accept : enable;
    assign wr_en       = ing_valid && beat_accept;

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            pkt_open   <= 1'b0;
            pkt_accept <= 1'b0;
        end else if (ing_valid) begin
            pkt_open   <= !ing_beat.tlast;
            pkt_accept <= beat_accept;
        end
    end

    // Local fill level mirrors the buffer so a dropped last is not counted
    assign buf_full = (level == FIFO_LEVEL_WIDTH'(BEAT_FIFO_DEPTH));
    assign wr_ok    = wr_en && !buf_full;
    assign rd_ok    = egr_valid && egr_ready;

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   level <= level + FIFO_LEVEL_WIDTH'(1);
                2'b01:   level <= level - FIFO_LEVEL_WIDTH'(1);
                default: level <= level;
            endcase
        end
    end

    assign ing_last_seen = wr_ok && ing_beat.tlast;
    assign egr_last_seen = rd_ok && egr_beat.tlast;

    //////////////////////////////////////////////////////////////////////
    // Buffer and counters

    beat_fifo #(
        .BEAT_T ( BEAT_T )
    ) u_fifo (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .wr_valid          ( wr_en             ),
        .wr_beat           ( ing_beat          ),
        .rd_ready          ( egr_ready         ),
        .clear             ( cnt_clear         ),
        .rd_valid          ( egr_valid         ),
        .rd_beat           ( egr_beat          ),
        .overflow          ( overflow          )
    );

    packet_counter u_ing_cnt (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .last_seen         ( ing_last_seen     ),
        .clear             ( cnt_clear         ),
        .count             ( ing_cnt           )
    );

    packet_counter u_egr_cnt (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .last_seen         ( egr_last_seen     ),
        .clear             ( cnt_clear         ),
        .count             ( egr_cnt           )
    );

    assign status.ing_pkt_cnt = ing_cnt;
    assign status.egr_pkt_cnt = egr_cnt;
    assign status.overflow    = overflow;

    // Mirrored level and buffer valid must agree
    a_level_tracks_fifo: assert property (
        @(posedge phys_port_clk_ifc) disable iff (!rst_n)
        (level != '0) == egr_valid
    );

endmodule

`default_nettype wire

//--- hw/port_router_top.sv
/* Multi-width echo router top */

`default_nettype none
`timescale 1ns/1ps

module port_router_top
    import port_router_pkg::*;
(
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst_n,

    // Ingress, no back-pressure
    input  beat_8b_t                 ing_8b        [NUM_8B_PORTS],
    input  logic [NUM_8B_PORTS-1:0]  ing_8b_valid,
    input  beat_32b_t                ing_32b       [NUM_32B_PORTS],
    input  logic [NUM_32B_PORTS-1:0] ing_32b_valid,

    // Control
    input  logic [NUM_PORTS-1:0]     port_enable,
    input  logic                     cnt_clear,

    // Egress
    input  logic [NUM_8B_PORTS-1:0]  egr_8b_ready,
    input  logic [NUM_32B_PORTS-1:0] egr_32b_ready,
    output beat_8b_t                 egr_8b        [NUM_8B_PORTS],
    output logic [NUM_8B_PORTS-1:0]  egr_8b_valid,
    output beat_32b_t                egr_32b       [NUM_32B_PORTS],
    output logic [NUM_32B_PORTS-1:0] egr_32b_valid,

    // Indexed by global port number
    output port_status_t             status        [NUM_PORTS]
);

    //////////////////////////////////////////////////////////////////////
    // 8-bit ports, global numbers 0 .. NUM_8B_PORTS-1

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_port_8b
        echo_port #(
            .BEAT_T ( beat_8b_t )
        ) u_port (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst_n             ( rst_n             ),
            .ing_valid         ( ing_8b_valid[i]   ),
            .ing_beat          ( ing_8b[i]         ),
            .enable            ( port_enable[i]    ),
            .cnt_clear         ( cnt_clear         ),
            .egr_ready         ( egr_8b_ready[i]   ),
            .egr_valid         ( egr_8b_valid[i]   ),
            .egr_beat          ( egr_8b[i]         ),
            .status            ( status[i]         )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // 32-bit ports, numbered after the 8-bit ones

    for (genvar j = 0; j < NUM_32B_PORTS; j++) begin : g_port_32b
        echo_port #(
            .BEAT_T ( beat_32b_t )
        ) u_port (
            .phys_port_clk_ifc ( phys_port_clk_ifc             ),
            .rst_n             ( rst_n                         ),
            .ing_valid         ( ing_32b_valid[j]              ),
            .ing_beat          ( ing_32b[j]                    ),
            .enable            ( port_enable[NUM_8B_PORTS + j] ),
            .cnt_clear         ( cnt_clear                     ),
            .egr_ready         ( egr_32b_ready[j]              ),
            .egr_valid         ( egr_32b_valid[j]              ),
            .egr_beat          ( egr_32b[j]                    ),
            .status            ( status[NUM_8B_PORTS + j]      )
        );
    end

endmodule

`default_nettype wire

//--- test/tb_util.svh
/* Echo router testbench helpers */

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h18aaf60f;

// Expected beats per port in the 32-bit beat layout, tlast is bit 0
logic [36:0]          sb_q       [NUM_PORTS][$];
logic [36:0]          exp_head   [NUM_PORTS];
logic [NUM_PORTS-1:0] exp_any = '0;
port_status_t         exp_status [NUM_PORTS];

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

// Raises the port enable together with beat enable_at, -1 leaves it alone
task automatic send_packet(input int p, input int len, input int enable_at);
    beat_8b_t  b8;
    beat_32b_t b32;
    for (int i = 0; i < len; i++) begin
        @(posedge phys_port_clk_ifc);
        if (p < NUM_8B_PORTS) begin
            b8.tdata = 8'(take_bits(8));
            b8.tlast = (i == len - 1);
            ing_8b[p] <= b8;
        end else begin
            b32.tdata = take_bits(32);
            b32.tkeep = 4'(take_bits(4));
            b32.tlast = (i == len - 1);
            ing_32b[p - NUM_8B_PORTS] <= b32;
        end
        if (i == enable_at) begin
            port_enable[p] <= 1'b1;
        end
        ing_v[p] <= 1'b1;
    end
    @(posedge phys_port_clk_ifc);
    ing_v[p] <= 1'b0;
    repeat (take_bits(2)) @(posedge phys_port_clk_ifc);
endtask

task automatic run_traffic(input int p, input int n_pkts);
    for (int k = 0; k < n_pkts; k++) begin
        send_packet(p, 1 + int'(take_bits(3)), -1);
    end
endtask

`endif

//--- test/port_router_tb.sv
/* Echo router testbench */

`default_nettype none
`timescale 1ns/1ps

module port_router_tb
    import port_router_pkg::*;
();

    localparam int TRAFFIC_PKTS    = 40;
    // Longest packet plus its idle cycles
    localparam int PKT_CYCLES      = 12;
    localparam int TEST_CYCLES     = 5 + (TRAFFIC_PKTS + 14) * PKT_CYCLES + 4 * BEAT_FIFO_DEPTH;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    logic                 phys_port_clk_ifc;
    logic                 rst_n;
    beat_8b_t             ing_8b   [NUM_8B_PORTS];
    beat_32b_t            ing_32b  [NUM_32B_PORTS];
    logic [NUM_PORTS-1:0] ing_v;
    logic [NUM_PORTS-1:0] port_enable;
    logic                 cnt_clear;
    logic [NUM_PORTS-1:0] egr_r = '0;
    logic [NUM_PORTS-1:0] hold_low;
    logic                 rand_ready;
    beat_8b_t             egr_8b   [NUM_8B_PORTS];
    beat_32b_t            egr_32b  [NUM_32B_PORTS];
    wire  [NUM_PORTS-1:0] egr_v;
    port_status_t         status   [NUM_PORTS];
    wire  [36:0]          ing_word [NUM_PORTS];
    wire  [36:0]          egr_word [NUM_PORTS];
    logic [NUM_PORTS-1:0] model_open;
    logic [NUM_PORTS-1:0] model_acc;
    int                   err_cnt      = 0;
    int                   base_err     = 0;
    int                   tests_run    = 0;
    int                   tests_failed = 0;

    `include "tb_util.svh"

    port_router_top u_dut (
        .phys_port_clk_ifc ( phys_port_clk_ifc                    ),
        .rst_n             ( rst_n                                ),
        .ing_8b            ( ing_8b                               ),
        .ing_8b_valid      ( ing_v[NUM_8B_PORTS-1:0]              ),
        .ing_32b           ( ing_32b                              ),
        .ing_32b_valid     ( ing_v[NUM_PORTS-1:NUM_8B_PORTS]      ),
        .port_enable       ( port_enable                          ),
        .cnt_clear         ( cnt_clear                            ),
        .egr_8b_ready      ( egr_r[NUM_8B_PORTS-1:0]              ),
        .egr_32b_ready     ( egr_r[NUM_PORTS-1:NUM_8B_PORTS]      ),
        .egr_8b            ( egr_8b                               ),
        .egr_8b_valid      ( egr_v[NUM_8B_PORTS-1:0]              ),
        .egr_32b           ( egr_32b                              ),
        .egr_32b_valid     ( egr_v[NUM_PORTS-1:NUM_8B_PORTS]      ),
        .status            ( status                               )
    );

    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_word_8b
        assign ing_word[i] = 37'(ing_8b[i]);
        assign egr_word[i] = 37'(egr_8b[i]);
    end
    for (genvar j = 0; j < NUM_32B_PORTS; j++) begin : g_word_32b
        assign ing_word[NUM_8B_PORTS + j] = ing_32b[j];
        assign egr_word[NUM_8B_PORTS + j] = egr_32b[j];
    end

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #10 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    always @(posedge phys_port_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (hold_low[p]) begin
                egr_r[p] <= 1'b0;
            end else begin
                egr_r[p] <= !rand_ready || (take_bits(2) != 0);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model of the enable rule and the full-buffer drops

    always @(posedge phys_port_clk_ifc) begin
        logic        acc;
        logic [36:0] head;
        int          lvl;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n) begin
                sb_q[p].delete();
                exp_status[p] = '0;
                model_open[p] = 1'b0;
                model_acc[p]  = 1'b0;
            end else begin
                lvl = sb_q[p].size();
                if (cnt_clear) begin
                    exp_status[p] = '0;
                end
                if (egr_v[p] && egr_r[p] && lvl > 0) begin
                    head = sb_q[p].pop_front();
                    if (head[0] && !cnt_clear && exp_status[p].egr_pkt_cnt != '1) begin
                        exp_status[p].egr_pkt_cnt += PKT_CNT_WIDTH'(1);
                    end
                end
                if (ing_v[p]) begin
                    acc = model_open[p] ? model_acc[p] : port_enable[p];
                    if (acc && lvl < BEAT_FIFO_DEPTH) begin
                        sb_q[p].push_back(ing_word[p]);
                        if (ing_word[p][0] && !cnt_clear && exp_status[p].ing_pkt_cnt != '1) begin
                            exp_status[p].ing_pkt_cnt += PKT_CNT_WIDTH'(1);
                        end
                    end else if (acc && !cnt_clear) begin
                        exp_status[p].overflow = 1'b1;
                    end
                    model_open[p] = !ing_word[p][0];
                    model_acc[p]  = acc;
                end
            end
            exp_any[p] = (sb_q[p].size() != 0);
            if (exp_any[p]) begin
                exp_head[p] = sb_q[p][0];
            end
        end
    end

    function automatic void log_error(input string msg);
        $display("Fail %0d ns: %s", $time, msg);
        err_cnt++;
    endfunction

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_check
        a_egr_valid: assert property (
            @(posedge phys_port_clk_ifc) disable iff (!rst_n) egr_v[p] == exp_any[p]
        ) else log_error($sformatf("port %0d egress valid differs from the model", p));

        a_egr_beat: assert property (
            @(posedge phys_port_clk_ifc) disable iff (!rst_n)
            egr_v[p] |-> egr_word[p] == exp_head[p]
        ) else log_error($sformatf("port %0d egress beat %h, expected %h", p,
                                   $sampled(egr_word[p]), $sampled(exp_head[p])));

        a_status: assert property (
            @(posedge phys_port_clk_ifc) disable iff (!rst_n) status[p] == exp_status[p]
        ) else log_error($sformatf("port %0d counters or overflow differ from the model", p));
    end

    task automatic wait_drained();
        do @(negedge phys_port_clk_ifc); while (egr_v != '0 || ing_v != '0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt != base_err) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - base_err);
        base_err = err_cnt;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge phys_port_clk_ifc);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n       <= 1'b0;
        ing_8b      <= '{default: '0};
        ing_32b     <= '{default: '0};
        ing_v       <= '0;
        port_enable <= '1;
        cnt_clear   <= 1'b0;
        hold_low    <= '0;
        rand_ready  <= 1'b0;
        repeat (3) @(posedge phys_port_clk_ifc);
        rst_n <= 1'b1;
        repeat (2) @(posedge phys_port_clk_ifc);
        end_test("reset state");

        rand_ready <= 1'b1;
        fork
            run_traffic(0, TRAFFIC_PKTS);
            run_traffic(1, TRAFFIC_PKTS);
            run_traffic(2, TRAFFIC_PKTS);
            run_traffic(3, TRAFFIC_PKTS);
        join
        end_test("random traffic");
        wait_drained();
        end_test("drained counts");

        // Port 2 enable rises inside its second packet
        @(posedge phys_port_clk_ifc);
        port_enable[2] <= 1'b0;
        send_packet(2, 5, -1);
        send_packet(2, 6, 3);
        send_packet(2, 4, -1);
        wait_drained();
        end_test("port enable");

        @(posedge phys_port_clk_ifc);
        hold_low[1] <= 1'b1;
        fork
            repeat (3) send_packet(1, 8, -1);
            run_traffic(0, 3);
            run_traffic(2, 3);
            run_traffic(3, 3);
        join
        @(posedge phys_port_clk_ifc);
        hold_low[1] <= 1'b0;
        wait_drained();
        end_test("overflow");

        fork
            run_traffic(0, 4);
            run_traffic(3, 4);
            begin
                repeat (8) @(posedge phys_port_clk_ifc);
                cnt_clear <= 1'b1;
                @(posedge phys_port_clk_ifc);
                cnt_clear <= 1'b0;
            end
        join
        wait_drained();
        end_test("counter clear");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
hw/port_router_pkg.sv
hw/packet_counter.sv
hw/beat_fifo.sv
hw/echo_port.sv
hw/port_router_top.sv
test/port_router_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the echo router testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f build.f \
    --top-module port_router_tb -o port_router_sim &&
    ./obj_dir/port_router_sim > sim.log 2>&1 ||
    echo "run.sh: build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "run.sh: passed" ||
    { echo "run.sh: failed"; exit 1; }
